//--- alu_pkg.sv
package alu_pkg;

    // rv64 data word
    typedef logic [63:0] xlen_t;

    // shift amount taken from the low bits of operand b
    typedef logic [5:0] shamt_t;

    // operand select code
    typedef logic [1:0] sel_t;

    localparam sel_t SEL_A_RS1 = 2'd1;
    localparam sel_t SEL_B_RS2 = 2'd1;
    localparam sel_t SEL_B_CSR = 2'd2;

    // codes 20..31 are unused and give a zero result
    typedef enum logic [4:0] {
        ADD   = 5'd0,
        SUB   = 5'd1,
        RET_A = 5'd2,
        RET_B = 5'd3,
        XOR   = 5'd4,
        OR    = 5'd5,
        AND   = 5'd6,
        SLL   = 5'd7,
        SRL   = 5'd8,
        SLT   = 5'd9,
        SLTU  = 5'd10,
        MUL   = 5'd11,
        REM   = 5'd12,
        DIVU  = 5'd13,
        REMU  = 5'd14,
        DIV   = 5'd15,
        SRA   = 5'd16,
        EQ    = 5'd17,
        GE    = 5'd18,
        GEU   = 5'd19
    } alu_op_e;

    typedef enum logic [1:0] {
        IDLE     = 2'd0,
        MUL_BUSY = 2'd1,
        DIV_BUSY = 2'd2
    } stage_state_e;

endpackage

//--- alu_int_core.sv
`timescale 1ns/100ps

module alu_int_core (
    input  alu_pkg::xlen_t a,
    input  alu_pkg::xlen_t b,
    input  logic [4:0]     operate,
    input  logic           word,
    output alu_pkg::xlen_t int_res
);

    alu_pkg::alu_op_e op;
    alu_pkg::shamt_t  sh;
    logic [31:0]      sra_word;
    alu_pkg::xlen_t   sra_full;
    logic             lt_s;
    logic             lt_u;

    assign op = alu_pkg::alu_op_e'(operate);
    assign sh = b[5:0];

    // word form shifts the low half only and zero-extends
    assign sra_word = $signed(a[31:0]) >>> sh;
    assign sra_full = $signed(a) >>> sh;

    assign lt_s = $signed(a) < $signed(b);
    assign lt_u = a < b;

    always_comb begin
        case (op)
            alu_pkg::ADD:   int_res = a + b;
            alu_pkg::SUB:   int_res = a - b;
            alu_pkg::RET_A: int_res = a;
            alu_pkg::RET_B: int_res = b;
            alu_pkg::XOR:   int_res = a ^ b;
            alu_pkg::OR:    int_res = a | b;
            alu_pkg::AND:   int_res = a & b;
            alu_pkg::SLL:   int_res = a << sh;
            alu_pkg::SRL:   int_res = a >> sh;
            alu_pkg::SRA:   int_res = word ? {32'd0, sra_word} : sra_full;
            alu_pkg::SLT:   int_res = {63'd0, lt_s};
            alu_pkg::SLTU:  int_res = {63'd0, lt_u};
            alu_pkg::EQ:    int_res = {63'd0, a == b};
            alu_pkg::GE:    int_res = {63'd0, !lt_s};
            alu_pkg::GEU:   int_res = {63'd0, !lt_u};
            // multi-cycle ops and unused codes
            default:        int_res = '0;
        endcase
    end

endmodule

//--- alu_mul_seq.sv
`timescale 1ns/100ps

module alu_mul_seq (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           start,
    input  logic           abort,
    input  alu_pkg::xlen_t a,
    input  alu_pkg::xlen_t b,
    output logic           done,
    output alu_pkg::xlen_t product
);

    logic           busy;
    logic [5:0]     cnt;
    alu_pkg::xlen_t mcand;
    alu_pkg::xlen_t mplier;
    alu_pkg::xlen_t acc;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            done <= 1'b0;
            cnt  <= '0;
        end else begin
            done <= 1'b0;
            if (abort) begin
                busy <= 1'b0;
            end else if (busy) begin
                cnt <= cnt + 6'd1;
                // 64th step finishes, product is ready next cycle
                if (cnt == 6'd63) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end else if (start) begin
                busy <= 1'b1;
                cnt  <= '0;
            end
        end
    end

    // one multiplier bit per cycle, bits above 63 fall off
    always_ff @(posedge clk) begin
        if (busy) begin
            if (mplier[0]) begin
                acc <= acc + mcand;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end else if (start) begin
            mcand  <= a;
            mplier <= b;
            acc    <= '0;
        end
    end

    assign product = acc;

endmodule

//--- alu_div_seq.sv
`timescale 1ns/100ps

module alu_div_seq (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           start,
    input  logic           abort,
    input  logic           is_signed,
    input  alu_pkg::xlen_t a,
    input  alu_pkg::xlen_t b,
    output logic           done,
    output alu_pkg::xlen_t quotient,
    output alu_pkg::xlen_t remainder
);

    typedef enum logic [1:0] {
        DIV_IDLE  = 2'd0,
        DIV_SETUP = 2'd1,
        DIV_RUN   = 2'd2
    } div_state_e;

    div_state_e     state;
    logic [5:0]     cnt;
    alu_pkg::xlen_t dvd_raw;
    alu_pkg::xlen_t dvs_raw;
    logic           sgn;
    alu_pkg::xlen_t dvs_mag;
    alu_pkg::xlen_t quo;
    alu_pkg::xlen_t rem;
    logic [64:0]    shifted;
    logic [64:0]    rem_sub;
    logic           fits;
    alu_pkg::xlen_t rem_step;
    alu_pkg::xlen_t quo_step;
    logic           dvs_zero;
    logic           overflow;
    logic           neg_q;
    logic           neg_r;

    // one restoring step with dividend bits entering from the top of quo
    assign shifted  = {rem, quo[63]};
    assign rem_sub  = shifted - {1'b0, dvs_mag};
    // no borrow out means the divisor fits
    assign fits     = !rem_sub[64];
    assign rem_step = fits ? rem_sub[63:0] : shifted[63:0];
    assign quo_step = {quo[62:0], fits};

    assign dvs_zero = (dvs_raw == '0);
    assign overflow = sgn && (dvd_raw == {1'b1, 63'd0}) && (dvs_raw == '1);
    // truncating division with the remainder taking the dividend's sign
    assign neg_q    = sgn && (dvd_raw[63] ^ dvs_raw[63]);
    assign neg_r    = sgn && dvd_raw[63];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= DIV_IDLE;
            done  <= 1'b0;
            cnt   <= '0;
        end else begin
            done <= 1'b0;
            if (abort) begin
                state <= DIV_IDLE;
            end else begin
                case (state)
                    DIV_IDLE: begin
                        if (start) begin
                            state <= DIV_SETUP;
                        end
                    end
                    DIV_SETUP: begin
                        state <= DIV_RUN;
                        cnt   <= '0;
                    end
                    DIV_RUN: begin
                        cnt <= cnt + 6'd1;
                        if (cnt == 6'd63) begin
                            state <= DIV_IDLE;
                            done  <= 1'b1;
                        end
                    end
                    default: state <= DIV_IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            DIV_IDLE: begin
                if (start) begin
                    dvd_raw <= a;
                    dvs_raw <= b;
                    sgn     <= is_signed;
                end
            end
            DIV_SETUP: begin
                quo     <= (sgn && dvd_raw[63]) ? -dvd_raw : dvd_raw;
                dvs_mag <= (sgn && dvs_raw[63]) ? -dvs_raw : dvs_raw;
                rem     <= '0;
            end
            DIV_RUN: begin
                quo <= quo_step;
                rem <= rem_step;
                // special cases still take the full latency
                if (cnt == 6'd63) begin
                    if (dvs_zero) begin
                        quotient  <= '1;
                        remainder <= dvd_raw;
                    end else if (overflow) begin
                        quotient  <= dvd_raw;
                        remainder <= '0;
                    end else begin
                        quotient  <= neg_q ? -quo_step : quo_step;
                        remainder <= neg_r ? -rem_step : rem_step;
                    end
                end
            end
            default: begin
            end
        endcase
    end

endmodule

//--- alu_stage_ctrl.sv
`timescale 1ns/100ps

module alu_stage_ctrl (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 flush,
    input  alu_pkg::xlen_t       pc,
    input  logic [4:0]           operate,
    input  alu_pkg::xlen_t       rs1,
    input  alu_pkg::xlen_t       rs2,
    input  alu_pkg::xlen_t       csr,
    input  alu_pkg::xlen_t       imm,
    input  alu_pkg::sel_t        sel_a,
    input  alu_pkg::sel_t        sel_b,
    input  logic                 word,
    input  alu_pkg::xlen_t       int_res,
    input  logic                 mul_done,
    input  alu_pkg::xlen_t       mul_product,
    input  logic                 div_done,
    input  alu_pkg::xlen_t       quotient,
    input  alu_pkg::xlen_t       remainder,
    output alu_pkg::xlen_t       a,
    output alu_pkg::xlen_t       b,
    output logic                 mul_start,
    output logic                 div_start,
    output logic                 div_signed,
    output alu_pkg::xlen_t       res,
    output logic                 alu_wait
);

    alu_pkg::stage_state_e state;
    alu_pkg::alu_op_e      op;
    logic                  is_mul;
    logic                  is_div;
    logic                  want_rem;

    assign op = alu_pkg::alu_op_e'(operate);

    // operand a: pc or rs1, rs1 cut to its low word when word is set
    always_comb begin
        if (sel_a == alu_pkg::SEL_A_RS1) begin
            a = word ? {32'd0, rs1[31:0]} : rs1;
        end else begin
            a = pc;
        end
    end

    always_comb begin
        case (sel_b)
            alu_pkg::SEL_B_RS2: b = rs2;
            alu_pkg::SEL_B_CSR: b = csr;
            default:            b = imm;
        endcase
    end

    assign is_mul     = (op == alu_pkg::MUL);
    assign is_div     = (op == alu_pkg::DIV) || (op == alu_pkg::DIVU) ||
                        (op == alu_pkg::REM) || (op == alu_pkg::REMU);
    assign want_rem   = (op == alu_pkg::REM) || (op == alu_pkg::REMU);
    assign div_signed = (op == alu_pkg::DIV) || (op == alu_pkg::REM);

    // units capture at the same edge the stage leaves IDLE
    assign mul_start = (state == alu_pkg::IDLE) && is_mul && !flush;
    assign div_start = (state == alu_pkg::IDLE) && is_div && !flush;
    assign alu_wait  = (state != alu_pkg::IDLE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= alu_pkg::IDLE;
            res   <= '0;
        end else if (flush) begin
            // drop whatever is in flight, res keeps its old value
            state <= alu_pkg::IDLE;
        end else begin
            case (state)
                alu_pkg::IDLE: begin
                    if (is_mul) begin
                        state <= alu_pkg::MUL_BUSY;
                    end else if (is_div) begin
                        state <= alu_pkg::DIV_BUSY;
                    end else begin
                        res <= int_res;
                    end
                end
                alu_pkg::MUL_BUSY: begin
                    if (mul_done) begin
                        res   <= mul_product;
                        state <= alu_pkg::IDLE;
                    end
                end
                alu_pkg::DIV_BUSY: begin
                    if (div_done) begin
                        res   <= want_rem ? remainder : quotient;
                        state <= alu_pkg::IDLE;
                    end
                end
                default: state <= alu_pkg::IDLE;
            endcase
        end
    end

endmodule

//--- alu_exec.sv
`timescale 1ns/100ps

module alu_exec (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 flush,
    input  alu_pkg::xlen_t       pc,
    input  logic [4:0]           operate,
    input  alu_pkg::xlen_t       rs1,
    input  alu_pkg::xlen_t       rs2,
    input  alu_pkg::xlen_t       csr,
    input  alu_pkg::xlen_t       imm,
    input  alu_pkg::sel_t        sel_a,
    input  alu_pkg::sel_t        sel_b,
    input  logic                 word,
    output alu_pkg::xlen_t       res,
    output logic                 alu_wait
);

    alu_pkg::xlen_t a;
    alu_pkg::xlen_t b;
    alu_pkg::xlen_t int_res;
    alu_pkg::xlen_t mul_product;
    alu_pkg::xlen_t quotient;
    alu_pkg::xlen_t remainder;
    logic           mul_start;
    logic           mul_done;
    logic           div_start;
    logic           div_signed;
    logic           div_done;

    alu_stage_ctrl ctrl0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush       (flush),
        .pc          (pc),
        .operate     (operate),
        .rs1         (rs1),
        .rs2         (rs2),
        .csr         (csr),
        .imm         (imm),
        .sel_a       (sel_a),
        .sel_b       (sel_b),
        .word        (word),
        .int_res     (int_res),
        .mul_done    (mul_done),
        .mul_product (mul_product),
        .div_done    (div_done),
        .quotient    (quotient),
        .remainder   (remainder),
        .a           (a),
        .b           (b),
        .mul_start   (mul_start),
        .div_start   (div_start),
        .div_signed  (div_signed),
        .res         (res),
        .alu_wait    (alu_wait)
    );

    alu_int_core core0 (
        .a       (a),
        .b       (b),
        .operate (operate),
        .word    (word),
        .int_res (int_res)
    );

    // flush doubles as abort for both sequential units
    alu_mul_seq mul0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (mul_start),
        .abort   (flush),
        .a       (a),
        .b       (b),
        .done    (mul_done),
        .product (mul_product)
    );

    alu_div_seq div0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (div_start),
        .abort     (flush),
        .is_signed (div_signed),
        .a         (a),
        .b         (b),
        .done      (div_done),
        .quotient  (quotient),
        .remainder (remainder)
    );

endmodule

//--- tb_alu_exec.sv
`timescale 1ns/100ps

module tb_alu_exec;

    logic           clk;
    logic           rst_n;
    logic           flush;
    alu_pkg::xlen_t pc;
    logic [4:0]     operate;
    alu_pkg::xlen_t rs1;
    alu_pkg::xlen_t rs2;
    alu_pkg::xlen_t csr;
    alu_pkg::xlen_t imm;
    alu_pkg::sel_t  sel_a;
    alu_pkg::sel_t  sel_b;
    logic           word;
    alu_pkg::xlen_t res;
    logic           alu_wait;

    // fields of the current vector
    logic [4:0]     f_op;
    alu_pkg::sel_t  f_sel_a;
    alu_pkg::sel_t  f_sel_b;
    logic           f_word;
    alu_pkg::xlen_t f_pc;
    alu_pkg::xlen_t f_rs1;
    alu_pkg::xlen_t f_rs2;
    alu_pkg::xlen_t f_csr;
    alu_pkg::xlen_t f_imm;
    logic           f_flush;
    alu_pkg::xlen_t f_exp;

    int             vec_no;
    alu_pkg::xlen_t prev_exp;

    alu_exec dut0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .flush    (flush),
        .pc       (pc),
        .operate  (operate),
        .rs1      (rs1),
        .rs2      (rs2),
        .csr      (csr),
        .imm      (imm),
        .sel_a    (sel_a),
        .sel_b    (sel_b),
        .word     (word),
        .res      (res),
        .alu_wait (alu_wait)
    );

    always #50 clk = ~clk;

    task automatic check_value(input string name, input alu_pkg::xlen_t got,
                               input alu_pkg::xlen_t exp);
        if (got !== exp) begin
            $display("Error %s vector %0d: got %h expected %h", name, vec_no, got, exp);
            $display("TEST FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    // inputs change just after the rising edge
    task automatic next_edge();
        @(posedge clk);
        #1;
    endtask

    task automatic wait_idle();
        int                    cycles;
        alu_pkg::stage_state_e st;
        cycles = 0;
        while (alu_wait) begin
            if (cycles == 200) begin
                st = dut0.ctrl0.state;
                $display("timeout: alu_wait still high after 200 cycles, state %s",
                         st.name());
                $display("TEST FAIL");
                $fatal(1, "timeout");
            end
            next_edge();
            cycles++;
        end
    endtask

    task automatic apply_vector();
        logic multi;
        multi = (f_op == alu_pkg::MUL) || (f_op == alu_pkg::DIV) ||
                (f_op == alu_pkg::DIVU) || (f_op == alu_pkg::REM) ||
                (f_op == alu_pkg::REMU);
        operate = f_op;
        sel_a   = f_sel_a;
        sel_b   = f_sel_b;
        word    = f_word;
        pc      = f_pc;
        rs1     = f_rs1;
        rs2     = f_rs2;
        csr     = f_csr;
        imm     = f_imm;
        next_edge();
        if (!multi) begin
            check_value("res", res, f_exp);
            prev_exp = f_exp;
        end else if (f_flush) begin
            // unit is running, kill it two edges later
            check_value("alu_wait", {63'd0, alu_wait}, 64'd1);
            next_edge();
            flush = 1'b1;
            next_edge();
            flush = 1'b0;
            check_value("alu_wait", {63'd0, alu_wait}, 64'd0);
            check_value("res", res, prev_exp);
        end else begin
            check_value("alu_wait", {63'd0, alu_wait}, 64'd1);
            wait_idle();
            check_value("res", res, f_exp);
            prev_exp = f_exp;
        end
    endtask

    initial begin
        int    fd;
        int    n;
        string line;
        clk      = 1'b0;
        rst_n    = 1'b0;
        flush    = 1'b0;
        pc       = '0;
        operate  = '0;
        rs1      = '0;
        rs2      = '0;
        csr      = '0;
        imm      = '0;
        sel_a    = '0;
        sel_b    = '0;
        word     = 1'b0;
        vec_no   = 0;
        prev_exp = '0;
        fd = $fopen("alu_exec_tests.txt", "r");
        if (fd == 0) begin
            $display("cannot open alu_exec_tests.txt");
            $display("TEST FAIL");
            $fatal(1, "missing data file");
        end
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_value("res", res, 64'd0);
        check_value("alu_wait", {63'd0, alu_wait}, 64'd0);
        while ($fgets(line, fd) != 0) begin
            // skip comments and blank lines
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h", f_op, f_sel_a, f_sel_b,
                        f_word, f_pc, f_rs1, f_rs2, f_csr, f_imm, f_flush, f_exp);
            if (n != 11) begin
                $display("malformed line in alu_exec_tests.txt: %s", line);
                $display("TEST FAIL");
                $fatal(1, "bad data file");
            end
            vec_no++;
            apply_vector();
        end
        $fclose(fd);
        if (vec_no == 0) begin
            $display("no test vectors were read");
            $display("TEST FAIL");
            $fatal(1, "empty data file");
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

//--- filelist.f
alu_pkg.sv
alu_int_core.sv
alu_mul_seq.sv
alu_div_seq.sv
alu_stage_ctrl.sv
alu_exec.sv
tb_alu_exec.sv

//--- Makefile
# Verilator build and run for the ALU execute stage

VERILATOR ?= verilator
TOP       ?= tb_alu_exec
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
TESTS     ?= alu_exec_tests.txt
VFLAGS    ?= --binary --timing --timescale 1ns/100ps -j 0

SRCS := $(filter %.sv %.v,$(shell cat $(FILELIST)))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# exit status of the simulator is the test result
run: $(SIM) $(TESTS)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)

//--- alu_exec_tests.txt
# op sel_a sel_b word pc rs1 rs2 csr imm flush expected_res, all hex
# flush set: mul/div flushed two edges after start, res keeps the previous result
00 1 1 0 1000 1234 10 0 0 0 1244
01 0 0 0 1000 1234 10 55 8 0 ff8
04 1 2 0 0 ff00ff00ff00ff00 0 0f0f0f0f0f0f0f0f 0 0 f00ff00ff00ff00f
06 1 3 0 0 ff00ff00ff00ff00 0 0 0ff00ff00ff00ff0 0 0f000f000f000f00
02 1 1 1 0 deadbeefcafef00d 0 0 0 0 cafef00d
03 0 2 0 4000 0 0 123456789abcdef0 0 0 123456789abcdef0
05 0 2 0 1000 0 0 f 0 0 100f
07 1 1 0 0 1 44 0 0 0 10
08 1 0 0 0 8000000000000000 0 0 7f 0 1
10 1 1 0 0 8000000000000000 4 0 0 0 f800000000000000
10 1 1 1 0 ffffffff80000000 4 0 0 0 f8000000
09 1 1 0 0 ffffffffffffffff 1 0 0 0 1
0a 1 1 0 0 ffffffffffffffff 1 0 0 0 0
11 1 0 0 0 5 0 0 5 0 1
12 1 1 0 0 ffffffffffffffff 1 0 0 0 0
13 1 1 0 0 ffffffffffffffff 1 0 0 0 1
0b 1 1 0 0 fffffffffffffffd 7 0 0 0 ffffffffffffffeb
0b 1 1 0 0 100000001 100000001 0 0 0 200000001
0f 1 1 0 0 fffffffffffffff9 2 0 0 0 fffffffffffffffd
0c 1 1 0 0 fffffffffffffff9 2 0 0 0 ffffffffffffffff
0d 1 1 0 0 64 7 0 0 0 e
0e 1 1 0 0 1234 0 0 0 0 1234
0d 1 1 0 0 1234 0 0 0 0 ffffffffffffffff
0f 1 1 0 0 8000000000000000 ffffffffffffffff 0 0 0 8000000000000000
0b 1 1 0 0 3 5 0 0 1 8000000000000000
0c 1 1 0 0 7 fffffffffffffffe 0 0 0 1
0f 1 1 0 0 64 7 0 0 1 1
0b 1 1 0 0 3 5 0 0 0 f
